// ==== include/decode_params.svh ====
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Width of one instruction word.
`define INST_W 16

// The major opcode sits in the top five bits of the word.
`define OPCODE_HI 15
`define OPCODE_LO 11

// General registers reachable through the rx, ry and rz fields.
`define REG_CNT 8

// Clock edges between inst_valid being sampled and ctl_valid.
`define PIPE_DEPTH 2

`endif

// ==== source/isa_pkg.sv ====
`include "decode_params.svh"

package isa_pkg;

        typedef logic [`INST_W-1:0] inst_t;
        typedef logic [`OPCODE_HI-`OPCODE_LO:0] opcode_t;

        // Major opcodes.
        localparam opcode_t OP_ADDSP3    = 5'b00000;
        localparam opcode_t OP_NOP       = 5'b00001;
        localparam opcode_t OP_B         = 5'b00010;
        localparam opcode_t OP_BEQZ      = 5'b00100;
        localparam opcode_t OP_BNEZ      = 5'b00101;
        localparam opcode_t OP_GRP_SHIFT = 5'b00110;
        localparam opcode_t OP_ADDIU3    = 5'b01000;
        localparam opcode_t OP_ADDIU     = 5'b01001;
        localparam opcode_t OP_GRP_SP    = 5'b01100;
        localparam opcode_t OP_LI        = 5'b01101;
        localparam opcode_t OP_CMPI      = 5'b01110;
        localparam opcode_t OP_LW_SP     = 5'b10010;
        localparam opcode_t OP_LW        = 5'b10011;
        localparam opcode_t OP_SW_SP     = 5'b11010;
        localparam opcode_t OP_SW        = 5'b11011;
        localparam opcode_t OP_GRP_RRR   = 5'b11100;
        localparam opcode_t OP_GRP_RR    = 5'b11101;
        localparam opcode_t OP_GRP_IH    = 5'b11110;

        // Sub-codes of the SP group, bits 10 to 8.
        localparam logic [2:0] SP_BTEQZ = 3'b000;
        localparam logic [2:0] SP_SW_RS = 3'b010;
        localparam logic [2:0] SP_ADDSP = 3'b011;
        localparam logic [2:0] SP_MTSP  = 3'b100;

        localparam logic [1:0] RRR_ADDU = 2'b01; // Bits 1 to 0.
        localparam logic [1:0] RRR_SUBU = 2'b11;

        // Sub-codes of the two-register group, bits 4 to 0.
        localparam logic [4:0] RR_PC_GRP = 5'b00000;
        localparam logic [4:0] RR_SLLV   = 5'b00100;
        localparam logic [4:0] RR_CMP    = 5'b01010;
        localparam logic [4:0] RR_AND    = 5'b01100;
        localparam logic [4:0] RR_OR     = 5'b01101;

        localparam logic [2:0] RR_JR   = 3'b000; // Bits 7 to 5 inside RR_PC_GRP.
        localparam logic [2:0] RR_MFPC = 3'b010;

        localparam logic IH_MFIH = 1'b0; // Bit 0.
        localparam logic IH_MTIH = 1'b1;

        localparam logic [1:0] SH_SLL = 2'b00; // Bits 1 to 0.
        localparam logic [1:0] SH_SRL = 2'b10;
        localparam logic [1:0] SH_SRA = 2'b11;

        typedef enum logic [4:0] {
                CLS_ADDIU, CLS_ADDIU3, CLS_ADDSP, CLS_ADDSP3, CLS_ADDU,
                CLS_AND, CLS_B, CLS_BEQZ, CLS_BNEZ, CLS_BTEQZ,
                CLS_CMP, CLS_CMPI, CLS_JR, CLS_LI, CLS_LW,
                CLS_LW_SP, CLS_MFIH, CLS_MFPC, CLS_MTIH, CLS_MTSP,
                CLS_NOP, CLS_OR, CLS_SLL, CLS_SLLV, CLS_SRA,
                CLS_SRL, CLS_SUBU, CLS_SW, CLS_SW_RS, CLS_SW_SP
        } inst_class_e;

endpackage

// ==== source/ctl_pkg.sv ====
package ctl_pkg;

        typedef enum logic [3:0] {
                ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_EQU,
                ALU_RETA, ALU_RETB, ALU_SLL, ALU_SLLV, ALU_SRA, ALU_SRL
        } alu_op_e;

        typedef enum logic [2:0] {A_NONE, A_REGA, A_SP, A_T, A_RZ} alu_a_sel_e;

        typedef enum logic [1:0] {B_NONE, B_REGB, B_IMM} alu_b_sel_e;

        typedef enum logic [2:0] {DST_NONE, DST_REG, DST_SP, DST_T, DST_IH} reg_dst_e;

        typedef enum logic [2:0] {WB_NONE, WB_ALU, WB_MEM, WB_IH, WB_PC} wb_data_sel_e;

        typedef enum logic [1:0] {WA_NONE, WA_RX, WA_RY, WA_RZ} wb_addr_sel_e;

        typedef enum logic [1:0] {JC_NONE, JC_ALWAYS, JC_ZERO, JC_NONZERO} jump_cond_e;

        typedef enum logic [1:0] {JS_NONE, JS_IMM, JS_ALU} jump_src_e;

        // Immediate extension: sign or zero, from the field width given.
        typedef enum logic [2:0] {
                IMM_NONE, IMM_SE3, IMM_SE4, IMM_SE7, IMM_ZE7, IMM_SE10
        } imm_sel_e;

        typedef enum logic [1:0] {RD_NONE, RD_REGA, RD_REGB, RD_RA} ram_data_sel_e;

        typedef struct packed {
                alu_op_e       alu_op;
                alu_a_sel_e    alu_a_sel;
                alu_b_sel_e    alu_b_sel;
                reg_dst_e      reg_dst;
                wb_data_sel_e  wb_data_sel;
                wb_addr_sel_e  wb_addr_sel;
                logic          ram_en;
                logic          ram_write;    // Only meaningful with ram_en set.
                jump_cond_e    jump_cond;
                jump_src_e     jump_src;
                imm_sel_e      imm_sel;
                ram_data_sel_e ram_data_sel;
        } ctl_word_t;

        // Every field idle, which is also the all-zero word.
        localparam ctl_word_t CTL_NOP = '{
                alu_op:       ALU_NOP,
                alu_a_sel:    A_NONE,
                alu_b_sel:    B_NONE,
                reg_dst:      DST_NONE,
                wb_data_sel:  WB_NONE,
                wb_addr_sel:  WA_NONE,
                ram_en:       1'b0,
                ram_write:    1'b0,
                jump_cond:    JC_NONE,
                jump_src:     JS_NONE,
                imm_sel:      IMM_NONE,
                ram_data_sel: RD_NONE
        };

endpackage

// ==== source/stage_reg.sv ====
`timescale 1ns/100ps

module stage_reg #(
        parameter type payload_t = logic
) (
        input  logic     clk_50mhz,
        input  logic     rst_n,
        input  logic     in_valid,
        input  payload_t in_data,
        output logic     out_valid,
        output payload_t out_data
);

        always_ff @(posedge clk_50mhz) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                        out_data  <= payload_t'('0);
                end else begin
                        out_valid <= in_valid;
                        if (in_valid) begin
                                out_data <= in_data; // Holds the last item while idle.
                        end
                end
        end

endmodule

// ==== source/inst_classifier.sv ====
`timescale 1ns/100ps
`include "decode_params.svh"

module inst_classifier
        import isa_pkg::*;
(
        input  inst_t       inst,
        output inst_class_e inst_class
);

        opcode_t opcode;

        assign opcode = inst[`OPCODE_HI:`OPCODE_LO];

        always_comb begin
                inst_class = CLS_NOP; // Anything not matched below stays a NOP.
                case (opcode)
                        OP_ADDIU:  inst_class = CLS_ADDIU;
                        OP_ADDIU3: inst_class = CLS_ADDIU3;
                        OP_ADDSP3: inst_class = CLS_ADDSP3;
                        OP_B:      inst_class = CLS_B;
                        OP_BEQZ:   inst_class = CLS_BEQZ;
                        OP_BNEZ:   inst_class = CLS_BNEZ;
                        OP_CMPI:   inst_class = CLS_CMPI;
                        OP_LI:     inst_class = CLS_LI;
                        OP_LW:     inst_class = CLS_LW;
                        OP_LW_SP:  inst_class = CLS_LW_SP;
                        OP_NOP:    inst_class = CLS_NOP;
                        OP_SW:     inst_class = CLS_SW;
                        OP_SW_SP:  inst_class = CLS_SW_SP;
                        OP_GRP_SP: begin
                                case (inst[10:8])
                                        SP_ADDSP: inst_class = CLS_ADDSP;
                                        SP_BTEQZ: inst_class = CLS_BTEQZ;
                                        SP_MTSP:  inst_class = CLS_MTSP;
                                        SP_SW_RS: inst_class = CLS_SW_RS;
                                endcase
                        end
                        OP_GRP_RRR: begin
                                case (inst[1:0])
                                        RRR_ADDU: inst_class = CLS_ADDU;
                                        RRR_SUBU: inst_class = CLS_SUBU;
                                endcase
                        end
                        OP_GRP_RR: begin
                                case (inst[4:0])
                                        RR_AND:  inst_class = CLS_AND;
                                        RR_CMP:  inst_class = CLS_CMP;
                                        RR_OR:   inst_class = CLS_OR;
                                        RR_SLLV: inst_class = CLS_SLLV;
                                        RR_PC_GRP: begin
                                                // JR and MFPC share the low field.
                                                case (inst[7:5])
                                                        RR_JR:   inst_class = CLS_JR;
                                                        RR_MFPC: inst_class = CLS_MFPC;
                                                endcase
                                        end
                                endcase
                        end
                        OP_GRP_IH: begin
                                case (inst[0])
                                        IH_MFIH: inst_class = CLS_MFIH;
                                        IH_MTIH: inst_class = CLS_MTIH;
                                endcase
                        end
                        OP_GRP_SHIFT: begin
                                case (inst[1:0])
                                        SH_SLL: inst_class = CLS_SLL;
                                        SH_SRA: inst_class = CLS_SRA;
                                        SH_SRL: inst_class = CLS_SRL;
                                endcase
                        end
                endcase
        end

endmodule

// ==== source/ctl_table.sv ====
`timescale 1ns/100ps

module ctl_table
        import isa_pkg::*;
        import ctl_pkg::*;
(
        input  inst_class_e inst_class,
        output ctl_word_t   ctl
);

        // Each field is decoded on its own; classes not named keep the idle value.
        always_comb begin
                ctl = CTL_NOP;

                case (inst_class)
                        CLS_ADDIU, CLS_ADDIU3, CLS_ADDSP, CLS_ADDSP3, CLS_ADDU,
                        CLS_LW, CLS_LW_SP, CLS_SW, CLS_SW_RS, CLS_SW_SP:
                                ctl.alu_op = ALU_ADD;
                        CLS_SUBU:             ctl.alu_op = ALU_SUB;
                        CLS_AND:              ctl.alu_op = ALU_AND;
                        CLS_OR:               ctl.alu_op = ALU_OR;
                        CLS_CMP, CLS_CMPI:    ctl.alu_op = ALU_EQU;
                        CLS_JR, CLS_MTIH, CLS_MTSP:
                                ctl.alu_op = ALU_RETA; // Pass rx through unchanged.
                        CLS_LI:               ctl.alu_op = ALU_RETB;
                        CLS_SLL:              ctl.alu_op = ALU_SLL;
                        CLS_SLLV:             ctl.alu_op = ALU_SLLV;
                        CLS_SRA:              ctl.alu_op = ALU_SRA;
                        CLS_SRL:              ctl.alu_op = ALU_SRL;
                endcase

                case (inst_class)
                        CLS_ADDIU, CLS_ADDIU3, CLS_ADDU, CLS_AND, CLS_BEQZ, CLS_BNEZ,
                        CLS_CMP, CLS_CMPI, CLS_JR, CLS_LW, CLS_MTIH, CLS_MTSP,
                        CLS_OR, CLS_SLLV, CLS_SUBU, CLS_SW:
                                ctl.alu_a_sel = A_REGA;
                        CLS_ADDSP, CLS_ADDSP3, CLS_LW_SP, CLS_SW_RS, CLS_SW_SP:
                                ctl.alu_a_sel = A_SP;
                        CLS_BTEQZ:                 ctl.alu_a_sel = A_T;
                        CLS_SLL, CLS_SRA, CLS_SRL: ctl.alu_a_sel = A_RZ;
                endcase

                case (inst_class)
                        CLS_ADDU, CLS_AND, CLS_CMP, CLS_OR, CLS_SLL, CLS_SLLV,
                        CLS_SRA, CLS_SRL, CLS_SUBU:
                                ctl.alu_b_sel = B_REGB;
                        CLS_ADDIU, CLS_ADDIU3, CLS_ADDSP, CLS_ADDSP3, CLS_CMPI, CLS_LI,
                        CLS_LW, CLS_LW_SP, CLS_SW, CLS_SW_RS, CLS_SW_SP:
                                ctl.alu_b_sel = B_IMM;
                endcase

                case (inst_class)
                        CLS_ADDIU, CLS_ADDIU3, CLS_ADDSP3, CLS_ADDU, CLS_AND, CLS_LI,
                        CLS_LW, CLS_LW_SP, CLS_MFIH, CLS_MFPC, CLS_OR, CLS_SLL,
                        CLS_SLLV, CLS_SRA, CLS_SRL, CLS_SUBU:
                                ctl.reg_dst = DST_REG;
                        CLS_ADDSP, CLS_MTSP: ctl.reg_dst = DST_SP;
                        CLS_CMP, CLS_CMPI:   ctl.reg_dst = DST_T;
                        CLS_MTIH:            ctl.reg_dst = DST_IH;
                endcase

                case (inst_class)
                        CLS_ADDIU, CLS_ADDIU3, CLS_ADDSP, CLS_ADDSP3, CLS_ADDU, CLS_AND,
                        CLS_CMP, CLS_CMPI, CLS_LI, CLS_MTIH, CLS_MTSP, CLS_OR,
                        CLS_SLL, CLS_SLLV, CLS_SRA, CLS_SRL, CLS_SUBU:
                                ctl.wb_data_sel = WB_ALU;
                        CLS_LW, CLS_LW_SP: ctl.wb_data_sel = WB_MEM;
                        CLS_MFIH:          ctl.wb_data_sel = WB_IH;
                        CLS_MFPC:          ctl.wb_data_sel = WB_PC;
                endcase

                case (inst_class)
                        CLS_ADDIU, CLS_ADDSP3, CLS_AND, CLS_LI, CLS_LW_SP, CLS_MFIH,
                        CLS_MFPC, CLS_OR, CLS_SLL, CLS_SRA, CLS_SRL:
                                ctl.wb_addr_sel = WA_RX;
                        CLS_ADDIU3, CLS_LW, CLS_SLLV: ctl.wb_addr_sel = WA_RY;
                        CLS_ADDU, CLS_SUBU:           ctl.wb_addr_sel = WA_RZ;
                endcase

                case (inst_class)
                        CLS_LW, CLS_LW_SP: ctl.ram_en = 1'b1;
                        CLS_SW, CLS_SW_RS, CLS_SW_SP: begin
                                ctl.ram_en    = 1'b1;
                                ctl.ram_write = 1'b1;
                        end
                endcase

                case (inst_class)
                        CLS_B, CLS_JR:       ctl.jump_cond = JC_ALWAYS;
                        CLS_BEQZ, CLS_BTEQZ: ctl.jump_cond = JC_ZERO;
                        CLS_BNEZ:            ctl.jump_cond = JC_NONZERO;
                endcase

                case (inst_class)
                        CLS_B, CLS_BEQZ, CLS_BNEZ, CLS_BTEQZ: ctl.jump_src = JS_IMM;
                        CLS_JR:                              ctl.jump_src = JS_ALU;
                endcase

                case (inst_class)
                        CLS_ADDIU3:     ctl.imm_sel = IMM_SE3;
                        CLS_LW, CLS_SW: ctl.imm_sel = IMM_SE4;
                        CLS_ADDIU, CLS_ADDSP, CLS_ADDSP3, CLS_BEQZ, CLS_BNEZ, CLS_BTEQZ,
                        CLS_CMPI, CLS_LW_SP, CLS_SW_RS, CLS_SW_SP:
                                ctl.imm_sel = IMM_SE7;
                        CLS_LI:         ctl.imm_sel = IMM_ZE7;
                        CLS_B:          ctl.imm_sel = IMM_SE10;
                endcase

                case (inst_class)
                        CLS_SW_SP: ctl.ram_data_sel = RD_REGA;
                        CLS_SW:    ctl.ram_data_sel = RD_REGB;
                        CLS_SW_RS: ctl.ram_data_sel = RD_RA; // Return address goes to the stack.
                endcase
        end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage
        import isa_pkg::*;
        import ctl_pkg::*;
(
        input  logic      clk_50mhz,
        input  logic      rst_n,
        input  logic      inst_valid,
        input  inst_t     inst,
        output logic      ctl_valid,
        output ctl_word_t ctl
);

        logic        fetch_valid;
        inst_t       fetch_inst;
        inst_class_e inst_class;
        ctl_word_t   ctl_next;

        stage_reg #(
                .payload_t (inst_t)
        ) fetch_reg (
                .clk_50mhz (clk_50mhz),
                .rst_n     (rst_n),
                .in_valid  (inst_valid),
                .in_data   (inst),
                .out_valid (fetch_valid),
                .out_data  (fetch_inst)
        );

        inst_classifier inst_classifier_i (
                .inst       (fetch_inst),
                .inst_class (inst_class)
        );

        ctl_table ctl_table_i (
                .inst_class (inst_class),
                .ctl        (ctl_next)
        );

        // Second edge: the decoded word is handed to the execute stage.
        stage_reg #(
                .payload_t (ctl_word_t)
        ) exec_reg (
                .clk_50mhz (clk_50mhz),
                .rst_n     (rst_n),
                .in_valid  (fetch_valid),
                .in_data   (ctl_next),
                .out_valid (ctl_valid),
                .out_data  (ctl)
        );

endmodule

// ==== bench/decode_stage_checker.sv ====
`timescale 1ns/100ps
`include "decode_params.svh"

module decode_stage_checker (
        input logic clk_50mhz,
        input logic rst_n,
        input logic inst_valid,
        input logic ctl_valid
);

        int fail_cnt = 0;

        // Reset empties the pipeline by the following edge.
        reset_clears_valid: assert property (
                @(posedge clk_50mhz) !rst_n |=> !ctl_valid
        ) else begin
                fail_cnt++;
                $error("ctl_valid is high in the cycle after reset");
        end

        accepted_comes_out: assert property (
                @(posedge clk_50mhz) disable iff (!rst_n)
                inst_valid |-> ##`PIPE_DEPTH ctl_valid
        ) else begin
                fail_cnt++;
                $error("An accepted instruction did not reach ctl_valid on time");
        end

        no_stray_valid: assert property (
                @(posedge clk_50mhz) disable iff (!rst_n)
                $rose(ctl_valid) |-> $past(inst_valid, `PIPE_DEPTH)
        ) else begin
                fail_cnt++;
                $error("ctl_valid rose without an instruction two cycles before");
        end

endmodule

// ==== bench/decode_stage_tb.sv ====
`timescale 1ns/100ps
`include "decode_params.svh"

module decode_stage_tb
        import isa_pkg::*;
        import ctl_pkg::*;
();

        logic      clk_50mhz;
        logic      rst_n;
        logic      inst_valid;
        inst_t     inst;
        logic      ctl_valid;
        ctl_word_t ctl;

        inst_t     vec_inst[$];
        int        vec_gap[$];
        ctl_word_t vec_exp[$];
        string     vec_name[$];

        ctl_word_t exp_q[$]; // Words still travelling through the pipeline.
        string     name_q[$];
        int        cycle_q[$];

        int cycle_cnt = 0;
        int err_cnt   = 0;
        int check_cnt = 0;

        decode_stage decode_stage_i (
                .clk_50mhz  (clk_50mhz),
                .rst_n      (rst_n),
                .inst_valid (inst_valid),
                .inst       (inst),
                .ctl_valid  (ctl_valid),
                .ctl        (ctl)
        );

        bind decode_stage decode_stage_checker checker_i (
                .clk_50mhz  (clk_50mhz),
                .rst_n      (rst_n),
                .inst_valid (inst_valid),
                .ctl_valid  (ctl_valid)
        );

        initial clk_50mhz = 1'b0;
        always #10 clk_50mhz = ~clk_50mhz;

        always @(posedge clk_50mhz) begin
                cycle_cnt <= cycle_cnt + 1;
        end

        // Opcode and sub-code bits that select the class; all other bits are operand fields.
        function automatic inst_t care_mask(inst_t word);
                inst_t mask;
                mask = '0;
                mask[`OPCODE_HI:`OPCODE_LO] = '1;
                case (word[`OPCODE_HI:`OPCODE_LO])
                        OP_GRP_SP:                mask[10:8] = '1;
                        OP_GRP_RRR, OP_GRP_SHIFT: mask[1:0] = '1;
                        OP_GRP_RR: begin
                                mask[4:0] = '1;
                                if (word[4:0] == 5'b00000) begin
                                        mask[7:5] = '1; // JR and MFPC split on bits 7 to 5.
                                end
                        end
                        OP_GRP_IH:                mask[0] = 1'b1;
                endcase
                return mask;
        endfunction

        task automatic load_vectors();
                int          fd;
                int          line_no;
                int          gap;
                string       line;
                string       name;
                logic [31:0] inst_raw;
                logic [31:0] exp_raw;
                fd = $fopen("bench/decode_stim.txt", "r");
                if (fd == 0) begin
                        err_cnt++;
                        $display("Could not open bench/decode_stim.txt, no vectors were run.");
                        return;
                end
                line_no = 0;
                while (!$feof(fd)) begin
                        line = "";
                        void'($fgets(line, fd));
                        line_no++;
                        if (line.len() < 2 || line[0] == "#") begin
                                continue;
                        end
                        if ($sscanf(line, "%h %d %h %s", inst_raw, gap, exp_raw, name) != 4) begin
                                err_cnt++;
                                $display("Line %0d of the stimulus file could not be read.",
                                         line_no);
                                continue;
                        end
                        vec_inst.push_back(inst_raw[`INST_W-1:0]);
                        vec_gap.push_back(gap);
                        vec_exp.push_back(ctl_word_t'(exp_raw[$bits(ctl_word_t)-1:0]));
                        vec_name.push_back(name);
                end
                $fclose(fd);
        endtask

        task automatic drive_vector(inst_t word, int gap, ctl_word_t exp_word, string name);
                repeat (gap) begin
                        @(negedge clk_50mhz);
                        inst_valid = 1'b0;
                end
                @(negedge clk_50mhz);
                inst_valid = 1'b1;
                inst       = word;
                exp_q.push_back(exp_word);
                name_q.push_back(name);
                cycle_q.push_back(cycle_cnt);
        endtask

        task automatic check_front();
                ctl_word_t exp_word;
                string     name;
                int        latency;
                exp_word = exp_q.pop_front();
                name     = name_q.pop_front();
                latency  = cycle_cnt - cycle_q.pop_front();
                check_cnt++;
                assert (ctl === exp_word) else begin
                        err_cnt++;
                        $display("** Error [%s] ctl expected %h, actual %h", name, exp_word, ctl);
                end
                assert (latency == `PIPE_DEPTH) else begin
                        err_cnt++;
                        $display("** Error [%s] latency expected %0d, actual %0d",
                                 name, `PIPE_DEPTH, latency);
                end
        endtask

        always @(negedge clk_50mhz) begin
                if (rst_n && ctl_valid) begin
                        if (exp_q.size() == 0) begin
                                err_cnt++;
                                $display("ctl_valid was high with no instruction in flight.");
                        end else begin
                                check_front();
                        end
                end
        end

        initial begin
                int    drain_wait;
                inst_t word;
                void'($urandom(32'hc9f5));
                rst_n      = 1'b0;
                inst_valid = 1'b0;
                inst       = '0;
                load_vectors();
                if (vec_inst.size() == 0) begin
                        err_cnt++;
                        $display("The stimulus file held no vectors.");
                end
                repeat (4) @(negedge clk_50mhz);
                rst_n = 1'b1;

                // Nothing has been sent yet, so the pipeline shows the idle word.
                repeat (3) begin
                        @(negedge clk_50mhz);
                        check_cnt++;
                        assert (ctl_valid === 1'b0 && ctl === 28'h0000000) else begin
                                err_cnt++;
                                $display("** Error [idle] valid/ctl expected 0/%h, actual %b/%h",
                                         28'h0000000, ctl_valid, ctl);
                        end
                end

                foreach (vec_inst[i]) begin
                        drive_vector(vec_inst[i], vec_gap[i], vec_exp[i], vec_name[i]);
                end
                foreach (vec_inst[i]) begin
                        word = (vec_inst[i] & care_mask(vec_inst[i]))
                               | (inst_t'($urandom()) & ~care_mask(vec_inst[i]));
                        drive_vector(word, vec_gap[i], vec_exp[i], {vec_name[i], "_rand"});
                end
                @(negedge clk_50mhz);
                inst_valid = 1'b0;

                drain_wait = 0;
                while (exp_q.size() != 0 && drain_wait < 20) begin
                        @(posedge clk_50mhz);
                        drain_wait++;
                end
                if (exp_q.size() != 0) begin
                        err_cnt++;
                        $display("Timed out with %0d control words never delivered.",
                                 exp_q.size());
                end
                repeat (3) @(negedge clk_50mhz); // Catch a stray ctl_valid after the last word.
                err_cnt += decode_stage_i.checker_i.fail_cnt;

                $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
                if (err_cnt == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

endmodule

// ==== bench/decode_stim.txt ====
# inst gap expected name  (inst and expected in hex, gap in decimal)
# gap is the number of idle cycles before the vector; expected is the 28-bit control word
4800 0 131280C addiu
4000 0 1313004 addiu3
6300 0 152200C addsp
0000 1 151280C addsp3
E001 0 1293800 addu
E80C 0 3292800 and
1000 2 00000B4 b
2000 0 020012C beqz
2800 0 02001AC bnez
6000 0 060012C bteqz
E80A 3 52B2000 cmp
7000 0 533200C cmpi
E800 0 62000C0 jr
6800 1 7112810 li
9800 0 1315408 lw
9000 0 1514C0C lw_sp
F000 0 0016800 mfih
E840 2 0018800 mfpc
F001 0 6242000 mtih
6400 0 6222000 mtsp
0800 0 0000000 nop
E80D 1 4292800 or
3000 0 8892800 sll
E804 0 9293000 sllv
3003 0 A892800 sra
3002 0 B892800 srl
E003 2 2293800 subu
D800 0 130060A sw
6200 0 150060F sw_rs
D000 0 150060D sw_sp
1800 1 0000000 bad_opcode
F800 0 0000000 bad_opcode_top
6100 0 0000000 bad_sp_sub
E000 0 0000000 bad_rrr_sub
E81F 2 0000000 bad_rr_sub
E820 0 0000000 bad_pc_sub
3001 0 0000000 bad_shift_sub

// ==== compile.f ====
+incdir+include
source/isa_pkg.sv
source/ctl_pkg.sv
source/stage_reg.sv
source/inst_classifier.sv
source/ctl_table.sv
source/decode_stage.sv
bench/decode_stage_checker.sv
bench/decode_stage_tb.sv
